//--- design/resolver_pkg.sv
// Resolver-side types: read kind, mode pin codes, measurement union and read result
`default_nettype none

package resolver_pkg;

    // Which quantity the converter reports in the next frame
    typedef enum logic {
        read_position = 1'b0,
        read_velocity = 1'b1
    } read_kind_t;

    // Mode pin codes that select the quantity on the chip's output register
    localparam logic [1:0] mode_position = 2'b00;
    localparam logic [1:0] mode_velocity = 2'b10;

    // The 16-bit data word of a frame means different things for the two reads.
    // Position is an unsigned fraction of a turn, velocity a two's complement rate
    typedef union packed {
        logic [15:0]        position;
        logic signed [15:0] velocity;
    } measurement_t;

    // One completed read as seen by the consumer
    typedef struct packed {
        read_kind_t   kind;
        measurement_t value;
        // Fault register contents sent in the same frame
        logic [7:0]   fault;
    } result_t;

endpackage

`default_nettype wire

//--- design/spi_pkg.sv
// SPI-side types: frame length, frame layout and frame response
`default_nettype none

package spi_pkg;

    // Bits clocked in per chip select
    localparam int frame_bits = 32;

    // Layout of one read frame, most significant bit first on the wire
    typedef struct packed {
        logic [15:0] measurement;
        // Always zero on the wire
        logic [7:0]  reserved;
        logic [7:0]  fault;
    } frame_t;

    // Returned by the master; frame is only meaningful while done is high
    typedef struct packed {
        logic   done;
        frame_t frame;
    } frame_response_t;

endpackage

`default_nettype wire

//--- design/spi_read_master.sv
// Read-only SPI master that clocks in one frame per accepted request
`default_nettype none

module spi_read_master #(
    parameter int clock_divider = 4
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 frame_valid,
    output logic                      frame_ready,
    output spi_pkg::frame_response_t  frame_response,
    input  wire logic                 miso,
    output logic                      sclk,
    output logic                      cs_n
);

    localparam int div_width = $clog2(clock_divider + 1);
    localparam int count_width = $clog2(spi_pkg::frame_bits + 1);

    typedef enum logic [1:0] {
        state_idle,
        state_shifting,
        state_finish
    } state_t;

    state_t                         state;
    // Counts system clocks within one SCLK half period
    logic [div_width-1:0]           div_count;
    // Rising SCLK edges seen in the current frame
    logic [count_width-1:0]         bit_count;
    logic [spi_pkg::frame_bits-1:0] shift_q;
    logic                           done_q;
    logic                           half_tick;
    logic                           rise_edge;
    logic                           all_bits;

    assign frame_ready = state == state_idle;
    assign half_tick = div_count == div_width'(clock_divider - 1);
    assign all_bits = bit_count == count_width'(spi_pkg::frame_bits);

    // SCLK goes high at the end of a low half period, which is where MISO is taken
    assign rise_edge = (state == state_shifting) && half_tick && !sclk;

    // The shift register does not move outside a frame, so it is stable with done
    assign frame_response = '{done: done_q, frame: spi_pkg::frame_t'(shift_q)};

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= state_idle;
            div_count <= '0;
            bit_count <= '0;
            sclk <= 1'b1;
            cs_n <= 1'b1;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                state_idle: begin
                    div_count <= '0;
                    bit_count <= '0;
                    if (frame_valid) begin
                        cs_n <= 1'b0;
                        state <= state_shifting;
                    end
                end
                state_shifting: begin
                    if (half_tick) begin
                        div_count <= '0;
                        if (sclk) begin
                            // Half a period after the last rise, chip select is released
                            if (all_bits) begin
                                cs_n <= 1'b1;
                                state <= state_finish;
                            end else begin
                                sclk <= 1'b0;
                            end
                        end else begin
                            sclk <= 1'b1;
                            bit_count <= bit_count + count_width'(1);
                        end
                    end else begin
                        div_count <= div_count + div_width'(1);
                    end
                end
                state_finish: begin
                    done_q <= 1'b1;
                    state <= state_idle;
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // MSB arrives first, so new bits enter at the bottom
    always_ff @(posedge clock) begin
        if (rise_edge) begin
            shift_q <= {shift_q[spi_pkg::frame_bits-2:0], miso};
        end
    end

endmodule

`default_nettype wire

//--- design/resolver_reader.sv
// Resolver read sequencer: mode pins, sample pulse, settling delay, frame request, result
`default_nettype none

module resolver_reader (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      start,
    input  wire resolver_pkg::read_kind_t  kind,
    input  wire logic [7:0]                sample_length,
    input  wire logic [7:0]                sample_delay,
    input  wire logic                      frame_ready,
    input  wire spi_pkg::frame_response_t  frame_response,
    output logic                           frame_valid,
    output logic [1:0]                     mode,
    output logic                           sample,
    output logic                           busy,
    output resolver_pkg::result_t          result,
    output logic                           result_valid
);

    typedef enum logic [1:0] {
        state_idle,
        state_sampling,
        state_settling,
        state_transferring
    } state_t;

    state_t                   state;
    // Shared between the sample pulse and the settling delay
    logic [7:0]               counter;
    resolver_pkg::read_kind_t kind_q;
    logic [7:0]               sample_length_q;
    logic [7:0]               sample_delay_q;
    logic                     accept;
    logic                     capture;
    logic                     sample_last;
    logic                     settle_last;

    assign accept = (state == state_idle) && start;
    assign capture = (state == state_transferring) && frame_response.done;

    // Sample is low for sample_length - 1 cycles, but never for less than one cycle
    assign sample_last = (sample_length_q < 8'd2) || (counter == sample_length_q - 8'd2);
    assign settle_last = counter == sample_delay_q;

    // Busy drops in the same cycle as the result pulse
    assign busy = state != state_idle;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= state_idle;
            counter <= '0;
            mode <= resolver_pkg::mode_position;
            sample <= 1'b1;
            frame_valid <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                state_idle: begin
                    if (start) begin
                        // Mode must be stable while the chip latches on the sample edge
                        if (kind == resolver_pkg::read_velocity) begin
                            mode <= resolver_pkg::mode_velocity;
                        end else begin
                            mode <= resolver_pkg::mode_position;
                        end
                        sample <= 1'b0;
                        counter <= '0;
                        state <= state_sampling;
                    end
                end
                state_sampling: begin
                    if (sample_last) begin
                        sample <= 1'b1;
                        counter <= '0;
                        state <= state_settling;
                    end else begin
                        counter <= counter + 8'd1;
                    end
                end
                state_settling: begin
                    // The output register needs time to update after sample rises
                    if (settle_last) begin
                        frame_valid <= 1'b1;
                        state <= state_transferring;
                    end else begin
                        counter <= counter + 8'd1;
                    end
                end
                state_transferring: begin
                    if (frame_valid && frame_ready) begin
                        frame_valid <= 1'b0;
                    end
                    if (frame_response.done) begin
                        result_valid <= 1'b1;
                        state <= state_idle;
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // Request fields are held for the whole read so the inputs may change freely
    always_ff @(posedge clock) begin
        if (accept) begin
            kind_q <= kind;
            sample_length_q <= sample_length;
            sample_delay_q <= sample_delay;
        end
        if (capture) begin
            result.kind <= kind_q;
            // Same bits either way, the kind field tells the consumer how to read them
            result.value.position <= frame_response.frame.measurement;
            result.fault <= frame_response.frame.fault;
        end
    end

endmodule

`default_nettype wire

//--- design/resolver_interface.sv
// Resolver converter read interface top: read sequencer and SPI master on the chip pins
`default_nettype none

module resolver_interface #(
    // System clocks per SCLK half period
    parameter int clock_divider = 4
) (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      start,
    input  wire resolver_pkg::read_kind_t  kind,
    input  wire logic [7:0]                sample_length,
    input  wire logic [7:0]                sample_delay,
    input  wire logic                      miso,
    output wire logic [1:0]                mode,
    output wire logic                      sample,
    output wire logic                      sclk,
    output wire logic                      cs_n,
    output wire logic                      busy,
    output wire resolver_pkg::result_t     result,
    output wire logic                      result_valid
);

    wire logic                     frame_valid;
    wire logic                     frame_ready;
    wire spi_pkg::frame_response_t frame_response;

    resolver_reader u_reader (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .kind           (kind),
        .sample_length  (sample_length),
        .sample_delay   (sample_delay),
        .frame_ready    (frame_ready),
        .frame_response (frame_response),
        .frame_valid    (frame_valid),
        .mode           (mode),
        .sample         (sample),
        .busy           (busy),
        .result         (result),
        .result_valid   (result_valid)
    );

    spi_read_master #(
        .clock_divider (clock_divider)
    ) u_spi (
        .clock          (clock),
        .reset          (reset),
        .frame_valid    (frame_valid),
        .frame_ready    (frame_ready),
        .frame_response (frame_response),
        .miso           (miso),
        .sclk           (sclk),
        .cs_n           (cs_n)
    );

endmodule

`default_nettype wire

//--- tb/resolver_chip_model.sv
// Behavioral resolver-to-digital converter that latches on sample and shifts out one frame
`default_nettype none

module resolver_chip_model (
    input  wire logic               sample,
    input  wire logic [1:0]         mode,
    input  wire logic               cs_n,
    input  wire logic               sclk,
    input  wire logic [15:0]        position_in,
    input  wire logic signed [15:0] velocity_in,
    input  wire logic [7:0]         fault_in,
    output logic                    miso
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0]                    position_q;
    logic signed [15:0]             velocity_q;
    logic [7:0]                     fault_q;
    logic [1:0]                     mode_q;
    logic [spi_pkg::frame_bits-1:0] shift_q;

    initial begin
        miso = 1'b0;
        position_q = '0;
        velocity_q = '0;
        fault_q = '0;
        mode_q = resolver_pkg::mode_position;
        shift_q = '0;
    end

    // The converter freezes both quantities and the mode on the falling edge of sample
    always @(negedge sample) begin
        position_q <= position_in;
        velocity_q <= velocity_in;
        fault_q <= fault_in;
        mode_q <= mode;
    end

    // Chip select loads the output register and puts the MSB on the line
    always @(negedge cs_n) begin
        spi_pkg::frame_t frame;
        frame.reserved = '0;
        frame.fault = fault_q;
        if (mode_q == resolver_pkg::mode_velocity) begin
            frame.measurement = velocity_q;
        end else begin
            frame.measurement = position_q;
        end
        shift_q <= frame;
        miso <= frame[spi_pkg::frame_bits-1];
    end

    // SCLK falls once before the first rise, so that first fall presents the MSB again
    always @(negedge sclk) begin
        if (!cs_n) begin
            miso <= shift_q[spi_pkg::frame_bits-1];
            shift_q <= shift_q << 1;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_resolver_interface.sv
// Testbench for the resolver read interface: clock, reset, stimulus, reference and checks
`default_nettype none

module tb_resolver_interface;
    timeunit 1ns;
    timeprecision 100ps;

    // One read for each fixed case, then the random batch
    localparam int random_reads = 40;
    localparam int request_count = random_reads + 4;
    localparam int cycles_per_request = 400;

    logic                     clock;
    logic                     reset;
    logic                     start;
    resolver_pkg::read_kind_t kind;
    logic [7:0]               sample_length;
    logic [7:0]               sample_delay;
    logic                     miso;
    logic [1:0]               mode;
    logic                     sample;
    logic                     sclk;
    logic                     cs_n;
    logic                     busy;
    resolver_pkg::result_t    result;
    logic                     result_valid;
    logic [15:0]              position_in;
    logic signed [15:0]       velocity_in;
    logic [7:0]               fault_in;

    resolver_pkg::result_t    expected_q[$];
    logic [1:0]               expected_mode;
    int                       requests_sent;
    int                       results_seen;
    integer                   seed = 31789;

    resolver_interface #(
        .clock_divider (2)
    ) u_resolver_interface (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .kind          (kind),
        .sample_length (sample_length),
        .sample_delay  (sample_delay),
        .miso          (miso),
        .mode          (mode),
        .sample        (sample),
        .sclk          (sclk),
        .cs_n          (cs_n),
        .busy          (busy),
        .result        (result),
        .result_valid  (result_valid)
    );

    resolver_chip_model u_chip (
        .sample      (sample),
        .mode        (mode),
        .cs_n        (cs_n),
        .sclk        (sclk),
        .position_in (position_in),
        .velocity_in (velocity_in),
        .fault_in    (fault_in),
        .miso        (miso)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic resolver_pkg::result_t expected_result(
        input resolver_pkg::read_kind_t read_kind,
        input logic [15:0]              position,
        input logic signed [15:0]       velocity,
        input logic [7:0]               fault
    );
        resolver_pkg::result_t r;
        r.kind = read_kind;
        // The frame carries whichever quantity the mode pins selected
        if (read_kind == resolver_pkg::read_velocity) begin
            r.value.velocity = velocity;
        end else begin
            r.value.position = position;
        end
        r.fault = fault;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic issue_read(
        input resolver_pkg::read_kind_t read_kind,
        input logic [15:0]              position,
        input logic signed [15:0]       velocity,
        input logic [7:0]               fault,
        input logic [7:0]               length,
        input logic [7:0]               delay
    );
        @(posedge clock);
        while (busy !== 1'b0) begin
            @(posedge clock);
        end
        position_in <= position;
        velocity_in <= velocity;
        fault_in <= fault;
        kind <= read_kind;
        sample_length <= length;
        sample_delay <= delay;
        start <= 1'b1;
        expected_q.push_back(expected_result(read_kind, position, velocity, fault));
        if (read_kind == resolver_pkg::read_velocity) begin
            expected_mode = resolver_pkg::mode_velocity;
        end else begin
            expected_mode = resolver_pkg::mode_position;
        end
        requests_sent++;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic wait_for_results();
        while (results_seen != requests_sent) begin
            @(posedge clock);
        end
    endtask

    // The opposite kind on the ignored pulse would show up in mode or in the result
    task automatic pulse_start_while_busy();
        check_value("busy", 32'd1, 32'(busy));
        kind <= resolver_pkg::read_kind_t'(~kind);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    // While sample is low the chip latches, so the mode pins must already match the request
    always @(posedge clock) begin
        if (reset && !sample) begin
            check_value("mode", 32'(expected_mode), 32'(mode));
        end
    end

    always @(posedge clock) begin
        resolver_pkg::result_t expected;
        if (reset && result_valid) begin
            if (expected_q.size() == 0) begin
                $display("result_valid pulsed at %0t ns with no read outstanding", $time);
                $display("SIMULATION FAILED");
                $fatal(1, "unexpected result");
            end else begin
                expected = expected_q.pop_front();
                check_value("busy", 32'd0, 32'(busy));
                check_value("result.kind", 32'(expected.kind), 32'(result.kind));
                if (expected.kind == resolver_pkg::read_velocity) begin
                    check_value("result.value.velocity", 32'(expected.value.velocity),
                                32'(result.value.velocity));
                end else begin
                    check_value("result.value.position", 32'(expected.value.position),
                                32'(result.value.position));
                end
                check_value("result.fault", 32'(expected.fault), 32'(result.fault));
                results_seen++;
            end
        end
    end

    initial begin
        repeat (request_count * cycles_per_request) @(posedge clock);
        $display("timeout: a read did not finish within %0d cycles per request",
                 cycles_per_request);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] word;
        int          i;
        reset = 1'b0;
        start = 1'b0;
        kind = resolver_pkg::read_position;
        sample_length = '0;
        sample_delay = '0;
        position_in = '0;
        velocity_in = '0;
        fault_in = '0;
        expected_mode = resolver_pkg::mode_position;
        requests_sent = 0;
        results_seen = 0;
        repeat (3) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);

        // Idle pin levels before any request
        check_value("sample", 32'd1, 32'(sample));
        check_value("cs_n", 32'd1, 32'(cs_n));
        check_value("sclk", 32'd1, 32'(sclk));
        check_value("mode", 32'd0, 32'(mode));
        check_value("busy", 32'd0, 32'(busy));
        check_value("result_valid", 32'd0, 32'(result_valid));

        issue_read(resolver_pkg::read_position, 16'hc35a, 16'sh7fff, 8'h41, 8'd3, 8'd5);
        wait_for_results();
        issue_read(resolver_pkg::read_velocity, 16'h0f0f, -16'sd1234, 8'h8c, 8'd1, 8'd0);
        wait_for_results();

        // New values after sample rises must not reach the frame
        issue_read(resolver_pkg::read_position, 16'h1234, 16'sh0222, 8'h3c, 8'd4, 8'd30);
        while (sample !== 1'b0) @(posedge clock);
        while (sample !== 1'b1) @(posedge clock);
        check_value("cs_n", 32'd1, 32'(cs_n));
        position_in <= 16'hedcb;
        velocity_in <= -16'sd77;
        fault_in <= 8'hff;
        wait_for_results();

        issue_read(resolver_pkg::read_velocity, 16'h5555, 16'sh1357, 8'h02, 8'd10, 8'd10);
        repeat (5) @(posedge clock);
        pulse_start_while_busy();
        wait_for_results();
        // A start remembered from the busy pulse would begin a second read right away
        repeat (4) begin
            @(posedge clock);
            check_value("busy", 32'd0, 32'(busy));
        end

        for (i = 0; i < random_reads; i++) begin
            word = $random(seed);
            issue_read(resolver_pkg::read_kind_t'(word[0]), 16'($random(seed)),
                       16'($random(seed)), 8'($random(seed)), 8'(word[13:8]),
                       8'(word[21:16]));
            wait_for_results();
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/resolver_pkg.sv
design/spi_pkg.sv
design/spi_read_master.sv
design/resolver_reader.sv
design/resolver_interface.sv
tb/resolver_chip_model.sv
tb/tb_resolver_interface.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the resolver interface testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_resolver_interface -f files.f

# The pipe hides the simulator's exit status, so the log decides the outcome
./obj_dir/Vtb_resolver_interface | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    echo "run.sh: testbench passed"
else
    echo "run.sh: testbench failed, see sim.log"
    exit 1
fi
